// File: all.f
lockin_pkg.sv
pi_param_if.sv
param_regs.sv
adc_frontend.sv
pi_controller.sv
dac_serializer.sv
tweezer_top.sv
tweezer_checker.sv
tb_tweezer.sv

// File: Bender.yml
package:
  name: tweezer_lockin

sources:
  - lockin_pkg.sv
  - pi_param_if.sv
  - param_regs.sv
  - adc_frontend.sv
  - pi_controller.sv
  - dac_serializer.sv
  - tweezer_top.sv
  - target: simulation
    files:
      - tweezer_checker.sv
      - tb_tweezer.sv

// File: tb_tweezer.sv
`timescale 1ns/1ns

module tb_tweezer import lockin_pkg::*; ();

   // one stimulus row, ch[0] is channel a
   typedef struct packed {
      logic             cfg_en;
      cfg_idx_t         idx;
      logic [15:0]      data;
      logic [1:0]       sel;
      logic             en;
      logic             clr;
      logic             rnd;
      logic [3:0][15:0] ch;
      logic [3:0]       sat;
   } row_t;

   localparam int ROW_CYCLES = 40;
   localparam int WAIT_LIMIT = 64;

   logic        clk_50;
   logic        rst;
   sample_t     adc_ch_a;
   sample_t     adc_ch_b;
   sample_t     adc_ch_c;
   sample_t     adc_ch_d;
   logic        adc_valid;
   logic [1:0]  ch_sel;
   logic        pi_enable;
   logic        pi_reset;
   logic        cfg_wr;
   cfg_idx_t    cfg_idx;
   logic [15:0] cfg_data;
   sample_t     pi_out;
   logic        pi_valid;
   logic [3:0]  sat_flags;
   logic        dac_sclk;
   logic        dac_cs_n;
   logic [1:0]  dac_sdo;

   row_t        rows [$];
   logic [31:0] lfsr;
   int          cyc;
   int          last_adc;

   // reference model state
   coeff_t      kp_m;
   coeff_t      ki_m;
   coeff_t      kp_act;
   coeff_t      ki_act;
   sample_t     sp_m;
   sample_t     lo_m;
   sample_t     hi_m;
   sample_t     dis_m;
   longint      integ_m;

   tweezer_top u_tweezer_top (.*);

   bind tweezer_top tweezer_checker u_checker (
      .clk_50,
      .rst,
      .dac_cs_n,
      .pi_valid,
      .pi_enable,
      .pi_out,
      .limit_lo (prm_if.limit_lo),
      .limit_hi (prm_if.limit_hi)
   );

   initial begin
      clk_50 = 1'b0;
      forever #2 clk_50 = ~clk_50;
   end

   // all stimulus moves on the falling edge
   task automatic tick();
      @(negedge clk_50);
      cyc++;
   endtask

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "stopped at first failing check");
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] exp,
                                  input logic [15:0] act);
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("timed out waiting for %s at %0t ns", what, $time);
      abort_run();
   endtask

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic rand16(output logic [15:0] v);
      for (int i = 0; i < 16; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[14:0], lfsr[0]};
      end
   endtask

   // rail codes flag a channel
   function automatic logic [3:0] sat_of(input logic [3:0][15:0] ch);
      logic [3:0] f;
      for (int i = 0; i < 4; i++) begin
         f[i] = (ch[i] == 16'h7FFF) || (ch[i] == 16'h8000);
      end
      return f;
   endfunction

   task automatic add_row(input logic cfg_en, input cfg_idx_t idx, input logic [15:0] data,
                          input logic [1:0] sel, input logic en, input logic clr,
                          input logic rnd, input logic [15:0] a, input logic [15:0] b,
                          input logic [15:0] c, input logic [15:0] d,
                          input logic [3:0] sat);
      rows.push_back({cfg_en, idx, data, sel, en, clr, rnd, d, c, b, a, sat});
   endtask

   task automatic fill_table();
      // cfg, idx, data, sel, en, clr, rnd, a, b, c, d, sat
      add_row(0, 0, 0, 0, 0, 0, 0, 16'h1234, 0, 0, 0, 4'h0);
      add_row(1, IDX_DISABLED_VALUE, 16'h0555, 3, 0, 0, 0, 16'h0100, 16'h0200, 16'h0300,
              16'h7FFF, 4'h8);
      add_row(1, IDX_SETPOINT, 16'h0400, 0, 1, 0, 0, 16'h0100, 16'h8000, 0, 0, 4'h2);
      // msb half alone leaves the gain at zero
      add_row(1, IDX_KP_MSB, 16'h0080, 0, 1, 0, 0, 16'h0100, 0, 0, 0, 4'h0);
      add_row(1, IDX_KP_LSB, 16'h0000, 0, 1, 0, 0, 16'h0100, 0, 0, 0, 4'h0);
      add_row(1, IDX_KI_MSB, 16'h0010, 1, 1, 0, 0, 0, 16'h0200, 0, 0, 4'h0);
      add_row(1, IDX_KI_LSB, 16'h8000, 1, 1, 0, 0, 0, 16'h0200, 0, 0, 4'h0);
      add_row(0, 0, 0, 2, 1, 0, 0, 0, 0, 16'hFC00, 0, 4'h0);
      // narrow limits, large error hits the rails
      add_row(1, IDX_LIMIT_HI, 16'h0200, 0, 1, 0, 0, 16'h8000, 0, 0, 0, 4'h1);
      add_row(0, 0, 0, 0, 1, 0, 0, 16'h8000, 0, 0, 0, 4'h1);
      add_row(1, IDX_LIMIT_LO, 16'hFE00, 2, 1, 0, 0, 0, 0, 16'h7FFF, 0, 4'h4);
      add_row(0, 0, 0, 0, 1, 0, 0, 16'h0400, 0, 0, 0, 4'h0);
      // integrator reset, then disable
      add_row(0, 0, 0, 0, 1, 1, 0, 16'h0300, 0, 0, 0, 4'h0);
      add_row(0, 0, 0, 0, 0, 0, 0, 16'h0300, 0, 0, 0, 4'h0);
      add_row(1, IDX_DISABLED_VALUE, 16'hFF00, 0, 0, 0, 0, 16'h0300, 0, 0, 0, 4'h0);
      // unknown index whose low bits alias the setpoint
      add_row(1, 8'h84, 16'h1234, 0, 1, 0, 0, 16'h0380, 0, 0, 0, 4'h0);
      add_row(1, IDX_LIMIT_HI, 16'h7FFF, 1, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(1, IDX_LIMIT_LO, 16'h8000, 2, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(0, 0, 0, 3, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      // small negative kp
      add_row(1, IDX_KP_MSB, 16'h03FF, 0, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(1, IDX_KP_LSB, 16'h1234, 1, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(1, IDX_KI_MSB, 16'h0000, 2, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(1, IDX_KI_LSB, 16'h4000, 2, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(0, 0, 0, 3, 1, 1, 1, 0, 0, 0, 0, 4'h0);
      add_row(0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(1, IDX_SETPOINT, 16'hC000, 1, 1, 0, 1, 0, 0, 0, 0, 4'h0);
      add_row(0, 0, 0, 3, 1, 0, 0, 16'h8000, 16'h7FFF, 16'h8000, 16'h7FFF, 4'hF);
   endtask

   // register bank as the host sees it
   task automatic apply_cfg(input cfg_idx_t idx, input logic [15:0] data);
      case (idx)
         IDX_KP_MSB: kp_m[25:16] = data[9:0];
         IDX_KP_LSB: begin
            kp_m[15:0] = data;
            kp_act = kp_m;
         end
         IDX_KI_MSB: ki_m[25:16] = data[9:0];
         IDX_KI_LSB: begin
            ki_m[15:0] = data;
            ki_act = ki_m;
         end
         IDX_SETPOINT:       sp_m = data;
         IDX_LIMIT_LO:       lo_m = data;
         IDX_LIMIT_HI:       hi_m = data;
         IDX_DISABLED_VALUE: dis_m = data;
         default: begin
         end
      endcase
   endtask

   // expected pi_out for one sample
   task automatic predict_out(input sample_t smp, input logic en, input logic clr,
                              output sample_t res);
      longint err;
      longint acc;
      longint o;
      longint lo_s;
      longint hi_s;
      lo_s = longint'(lo_m) <<< COEFF_FRAC;
      hi_s = longint'(hi_m) <<< COEFF_FRAC;
      if (!en) begin
         integ_m = 0;
         res = dis_m;
      end else begin
         err = longint'(sp_m) - longint'(smp);
         if (clr) begin
            acc = 0;
         end else begin
            acc = integ_m + longint'(ki_act) * err;
            if (acc > hi_s) acc = hi_s;
            if (acc < lo_s) acc = lo_s;
         end
         integ_m = acc;
         o = (longint'(kp_act) * err + acc) >>> COEFF_FRAC;
         if (o > hi_m) res = hi_m;
         else if (o < lo_m) res = lo_m;
         else res = sample_t'(o);
      end
   endtask

   // bits taken mid high phase of dac_sclk
   task automatic check_frame(input logic [15:0] exp0, input logic [15:0] exp1);
      logic [15:0] w0;
      logic [15:0] w1;
      int          n;
      int          guard;
      guard = 0;
      while (dac_cs_n && guard < WAIT_LIMIT) begin
         tick();
         guard++;
      end
      if (dac_cs_n) report_timeout("dac_cs_n to fall");
      n = 0;
      guard = 0;
      while (n < 16 && guard < WAIT_LIMIT) begin
         if (dac_sclk && !dac_cs_n) begin
            w0 = {w0[14:0], dac_sdo[0]};
            w1 = {w1[14:0], dac_sdo[1]};
            n++;
         end
         tick();
         guard++;
      end
      if (n < 16) report_timeout("16 dac bits");
      assert (w0 === exp0) else report_mismatch("dac_sdo[0] word", exp0, w0);
      assert (w1 === exp1) else report_mismatch("dac_sdo[1] word", exp1, w1);
      guard = 0;
      while (!dac_cs_n && guard < WAIT_LIMIT) begin
         tick();
         guard++;
      end
      if (!dac_cs_n) report_timeout("dac_cs_n to rise");
   endtask

   task automatic run_row(input row_t r);
      row_t        cur;
      logic [15:0] v;
      logic [15:0] exp_smp;
      sample_t     exp_out;
      int          guard;
      cur = r;
      if (cur.rnd) begin
         for (int i = 0; i < 4; i++) begin
            rand16(v);
            cur.ch[i] = v;
         end
         cur.sat = sat_of(cur.ch);
      end
      tick();
      cfg_wr    = cur.cfg_en;
      cfg_idx   = cur.idx;
      cfg_data  = cur.data;
      ch_sel    = cur.sel;
      pi_enable = cur.en;
      pi_reset  = cur.clr;
      adc_ch_a  = cur.ch[0];
      adc_ch_b  = cur.ch[1];
      adc_ch_c  = cur.ch[2];
      adc_ch_d  = cur.ch[3];
      if (cur.cfg_en) apply_cfg(cur.idx, cur.data);
      tick();
      cfg_wr = 1'b0;
      // fixed adc rate
      while (cyc - last_adc < ROW_CYCLES) tick();
      adc_valid = 1'b1;
      last_adc  = cyc;
      exp_smp   = cur.ch[cur.sel];
      predict_out(sample_t'(exp_smp), cur.en, cur.clr, exp_out);
      tick();
      adc_valid = 1'b0;
      guard = 0;
      while (!pi_valid && guard < WAIT_LIMIT) begin
         tick();
         guard++;
      end
      if (!pi_valid) report_timeout("pi_valid");
      // one register stage in the front end and one in the loop
      assert (guard == 1) else begin
         $display("pi_valid came %0d cycles after adc_valid instead of 2", guard + 1);
         abort_run();
      end
      assert (pi_out === exp_out) else report_mismatch("pi_out", exp_out, pi_out);
      assert (sat_flags === cur.sat) else report_mismatch("sat_flags", cur.sat, sat_flags);
      check_frame(exp_out + DAC_OFFSET, exp_smp + DAC_OFFSET);
   endtask

   initial begin
      lfsr      = 32'h8021_a972;
      cyc       = 0;
      last_adc  = -ROW_CYCLES;
      rst       = 1'b1;
      adc_ch_a  = '0;
      adc_ch_b  = '0;
      adc_ch_c  = '0;
      adc_ch_d  = '0;
      adc_valid = 1'b0;
      ch_sel    = '0;
      pi_enable = 1'b0;
      pi_reset  = 1'b0;
      cfg_wr    = 1'b0;
      cfg_idx   = '0;
      cfg_data  = '0;
      // model matches the reset values of the bank
      kp_m      = '0;
      ki_m      = '0;
      kp_act    = '0;
      ki_act    = '0;
      sp_m      = '0;
      lo_m      = 16'h8000;
      hi_m      = 16'h7FFF;
      dis_m     = '0;
      integ_m   = 0;
      fill_table();
      repeat (4) tick();
      rst = 1'b0;
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      repeat (8) tick();
      if (u_tweezer_top.u_checker.fail_cnt == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("%0d concurrent assertion failures", u_tweezer_top.u_checker.fail_cnt);
         abort_run();
      end
   end

endmodule

// File: tweezer_checker.sv
`timescale 1ns/1ns

module tweezer_checker import lockin_pkg::*; (
   input logic    clk_50,
   input logic    rst,
   input logic    dac_cs_n,
   input logic    pi_valid,
   input logic    pi_enable,
   input sample_t pi_out,
   input sample_t limit_lo,
   input sample_t limit_hi
);

   // two sclk phases per dac bit
   localparam int FRAME_CYC = 32;

   // failures seen so far
   int fail_cnt = 0;

   cs_frame_len: assert property (@(posedge clk_50) disable iff (rst)
      $fell(dac_cs_n) |-> !dac_cs_n [*FRAME_CYC] ##1 dac_cs_n)
   else begin
      $error("dac_cs_n low phase is not %0d cycles", FRAME_CYC);
      fail_cnt++;
   end

   // fresh enabled result sits inside the limits
   out_in_range: assert property (@(posedge clk_50) disable iff (rst)
      pi_valid && pi_enable |-> (pi_out >= limit_lo) && (pi_out <= limit_hi))
   else begin
      $error("pi_out %h outside %h .. %h", pi_out, limit_lo, limit_hi);
      fail_cnt++;
   end

   valid_pulse: assert property (@(posedge clk_50) disable iff (rst)
      pi_valid |=> !pi_valid)
   else begin
      $error("pi_valid high two cycles in a row");
      fail_cnt++;
   end

endmodule

// File: tweezer_top.sv
`timescale 1ns/1ns

module tweezer_top import lockin_pkg::*; (
   input  logic        clk_50,
   input  logic        rst,
   input  sample_t     adc_ch_a,
   input  sample_t     adc_ch_b,
   input  sample_t     adc_ch_c,
   input  sample_t     adc_ch_d,
   input  logic        adc_valid,
   input  logic [1:0]  ch_sel,
   input  logic        pi_enable,
   input  logic        pi_reset,
   input  logic        cfg_wr,
   input  cfg_idx_t    cfg_idx,
   input  logic [15:0] cfg_data,
   output sample_t     pi_out,
   output logic        pi_valid,
   output logic [3:0]  sat_flags,
   output logic        dac_sclk,
   output logic        dac_cs_n,
   output logic [1:0]  dac_sdo
);

   // one adc per quadrant of the detector
   localparam int N_CHANNELS = 4;
   localparam int DAC_BITS   = 16;

   sample_t adc_data [N_CHANNELS];
   sample_t sample;
   logic    sample_valid;

   // ch_sel 0 picks channel a
   assign adc_data[0] = adc_ch_a;
   assign adc_data[1] = adc_ch_b;
   assign adc_data[2] = adc_ch_c;
   assign adc_data[3] = adc_ch_d;

   pi_param_if prm_if ();

   param_regs u_param_regs (
      .clk_50   (clk_50),
      .rst      (rst),
      .cfg_wr   (cfg_wr),
      .cfg_idx  (cfg_idx),
      .cfg_data (cfg_data),
      .prm      (prm_if.source)
   );

   adc_frontend #(.N_CHANNELS(N_CHANNELS)) u_adc_frontend (
      .clk_50       (clk_50),
      .rst          (rst),
      .adc_data     (adc_data),
      .adc_valid    (adc_valid),
      .ch_sel       (ch_sel),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sat_flags    (sat_flags)
   );

   pi_controller u_pi_controller (
      .clk_50       (clk_50),
      .rst          (rst),
      .sample       (sample),
      .sample_valid (sample_valid),
      .pi_enable    (pi_enable),
      .pi_reset     (pi_reset),
      .prm          (prm_if.sink),
      .pi_out       (pi_out),
      .pi_valid     (pi_valid)
   );

   // sample still holds the value behind this pi_out
   dac_serializer #(.DAC_BITS(DAC_BITS)) u_dac_serializer (
      .clk_50   (clk_50),
      .rst      (rst),
      .pi_out   (pi_out),
      .sample   (sample),
      .pi_valid (pi_valid),
      .dac_sclk (dac_sclk),
      .dac_cs_n (dac_cs_n),
      .dac_sdo  (dac_sdo)
   );

endmodule

// File: dac_serializer.sv
`timescale 1ns/1ns

module dac_serializer import lockin_pkg::*; #(
   parameter int DAC_BITS = 16
) (
   input  logic       clk_50,
   input  logic       rst,
   input  sample_t    pi_out,
   input  sample_t    sample,
   input  logic       pi_valid,
   output logic       dac_sclk,
   output logic       dac_cs_n,
   output logic [1:0] dac_sdo
);

   localparam int CNT_W = $clog2(DAC_BITS);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_GAP
   } dac_state_t;

   dac_state_t          state;
   logic [CNT_W-1:0]    bit_cnt;
   logic [DAC_BITS-1:0] sh0;
   logic [DAC_BITS-1:0] sh1;
   dac_word_t           ch0_word;
   dac_word_t           ch1_word;

   // ch0 pi output, ch1 monitored input
   assign ch0_word = dac_word_t'(pi_out) + DAC_OFFSET;
   assign ch1_word = dac_word_t'(sample) + DAC_OFFSET;

   // both dacs share sclk and cs, msb first
   assign dac_sdo = {sh1[DAC_BITS-1], sh0[DAC_BITS-1]};

   always_ff @(posedge clk_50) begin
      if (rst) begin
         state    <= ST_IDLE;
         bit_cnt  <= '0;
         dac_cs_n <= 1'b1;
         dac_sclk <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               // a result during a frame is simply lost
               if (pi_valid) begin
                  state    <= ST_SHIFT;
                  bit_cnt  <= '0;
                  dac_cs_n <= 1'b0;
               end
            end
            ST_SHIFT: begin
               dac_sclk <= ~dac_sclk;
               // data moves on the falling edge
               if (dac_sclk) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == CNT_W'(DAC_BITS - 1)) begin
                     state    <= ST_GAP;
                     dac_cs_n <= 1'b1;
                  end
               end
            end
            // one cycle with cs high between frames
            ST_GAP: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // left justified load, shift after each high sclk phase
   always_ff @(posedge clk_50) begin
      if (state == ST_IDLE && pi_valid) begin
         sh0 <= ch0_word[$bits(dac_word_t)-1 -: DAC_BITS];
         sh1 <= ch1_word[$bits(dac_word_t)-1 -: DAC_BITS];
      end else if (state == ST_SHIFT && dac_sclk) begin
         sh0 <= {sh0[DAC_BITS-2:0], 1'b0};
         sh1 <= {sh1[DAC_BITS-2:0], 1'b0};
      end
   end

endmodule

// File: pi_controller.sv
`timescale 1ns/1ns

module pi_controller import lockin_pkg::*; (
   input  logic     clk_50,
   input  logic     rst,
   input  sample_t  sample,
   input  logic     sample_valid,
   input  logic     pi_enable,
   input  logic     pi_reset,
   pi_param_if.sink prm,
   output sample_t  pi_out,
   output logic     pi_valid
);

   // error is one bit wider than a sample
   localparam int ERR_W  = SAMPLE_W + 1;
   localparam int PROD_W = COEFF_W + ERR_W;
   // integrator holds the limits scaled by 2^COEFF_FRAC
   localparam int INT_W  = SAMPLE_W + COEFF_FRAC;
   // headroom for product plus integrator
   localparam int SUM_W  = PROD_W + 2;

   coeff_t                    kp_sh;
   coeff_t                    ki_sh;
   logic signed [INT_W-1:0]   integ;
   logic signed [ERR_W-1:0]   err;
   logic signed [PROD_W-1:0]  kp_prod;
   logic signed [PROD_W-1:0]  ki_prod;
   logic signed [SUM_W-1:0]   int_sum;
   logic signed [SUM_W-1:0]   int_lo;
   logic signed [SUM_W-1:0]   int_hi;
   logic signed [SUM_W-1:0]   int_next;
   logic signed [SUM_W-1:0]   out_sum;
   logic signed [SUM_W-1:0]   out_shift;
   sample_t                   out_clamp;

   // setpoint minus sample, no wrap
   assign err     = ERR_W'(prm.setpoint) - ERR_W'(sample);
   assign kp_prod = kp_sh * err;
   assign ki_prod = ki_sh * err;

   assign int_sum = SUM_W'(integ) + SUM_W'(ki_prod);
   assign int_lo  = SUM_W'(prm.limit_lo) <<< COEFF_FRAC;
   assign int_hi  = SUM_W'(prm.limit_hi) <<< COEFF_FRAC;

   // anti windup, integrator never leaves the output range
   always_comb begin
      if (pi_reset) begin
         // proportional term alone on a reset sample
         int_next = '0;
      end else if (int_sum > int_hi) begin
         int_next = int_hi;
      end else if (int_sum < int_lo) begin
         int_next = int_lo;
      end else begin
         int_next = int_sum;
      end
   end

   assign out_sum   = SUM_W'(kp_prod) + int_next;
   // back to Q1.15
   assign out_shift = out_sum >>> COEFF_FRAC;

   always_comb begin
      if (out_shift > SUM_W'(prm.limit_hi)) begin
         out_clamp = prm.limit_hi;
      end else if (out_shift < SUM_W'(prm.limit_lo)) begin
         out_clamp = prm.limit_lo;
      end else begin
         out_clamp = sample_t'(out_shift[SAMPLE_W-1:0]);
      end
   end

   always_ff @(posedge clk_50) begin
      if (rst) begin
         kp_sh    <= '0;
         ki_sh    <= '0;
         integ    <= '0;
         pi_out   <= '0;
         pi_valid <= 1'b0;
      end else begin
         // shadow gains swap only on the strobe
         if (prm.kp_update) begin
            kp_sh <= prm.kp;
         end
         if (prm.ki_update) begin
            ki_sh <= prm.ki;
         end
         pi_valid <= sample_valid;
         // cleared every cycle while held off or in reset
         if (!pi_enable || pi_reset) begin
            integ <= '0;
         end else if (sample_valid) begin
            integ <= int_next[INT_W-1:0];
         end
         if (sample_valid) begin
            pi_out <= pi_enable ? out_clamp : prm.disabled_value;
         end
      end
   end

endmodule

// File: adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend import lockin_pkg::*; #(
   parameter int N_CHANNELS = 4
) (
   input  logic                  clk_50,
   input  logic                  rst,
   input  sample_t               adc_data [N_CHANNELS],
   input  logic                  adc_valid,
   input  logic [1:0]            ch_sel,
   output sample_t               sample,
   output logic                  sample_valid,
   output logic [N_CHANNELS-1:0] sat_flags
);

   logic [N_CHANNELS-1:0] sat_now;

   // clipped channel sits at either rail code
   always_comb begin
      for (int i = 0; i < N_CHANNELS; i++) begin
         sat_now[i] = (adc_data[i] == SAT_POS) || (adc_data[i] == SAT_NEG);
      end
   end

   // flags follow the adc strobe, held in between
   always_ff @(posedge clk_50) begin
      if (rst) begin
         sample_valid <= 1'b0;
         sat_flags    <= '0;
      end else begin
         sample_valid <= adc_valid;
         if (adc_valid) begin
            sat_flags <= sat_now;
         end
      end
   end

   // channel fed to the loop
   always_ff @(posedge clk_50) begin
      if (adc_valid) begin
         sample <= adc_data[ch_sel];
      end
   end

endmodule

// File: param_regs.sv
`timescale 1ns/1ns

module param_regs import lockin_pkg::*; (
   input  logic        clk_50,
   input  logic        rst,
   input  logic        cfg_wr,
   input  cfg_idx_t    cfg_idx,
   input  logic [15:0] cfg_data,
   pi_param_if.source  prm
);

   logic kp_lsb_wr;
   logic ki_lsb_wr;

   // lsb half completes a coefficient
   assign kp_lsb_wr = cfg_wr && (cfg_idx == IDX_KP_LSB);
   assign ki_lsb_wr = cfg_wr && (cfg_idx == IDX_KI_LSB);

   // update strobes line up with the new lsb half
   always_ff @(posedge clk_50) begin
      if (rst) begin
         prm.kp_update <= 1'b0;
         prm.ki_update <= 1'b0;
      end else begin
         prm.kp_update <= kp_lsb_wr;
         prm.ki_update <= ki_lsb_wr;
      end
   end

   always_ff @(posedge clk_50) begin
      if (rst) begin
         prm.kp             <= '0;
         prm.ki             <= '0;
         prm.setpoint       <= '0;
         // full scale until the host narrows it
         prm.limit_lo       <= 16'h8000;
         prm.limit_hi       <= 16'h7FFF;
         prm.disabled_value <= '0;
      end else if (cfg_wr) begin
         case (cfg_idx)
            // msb write carries only the low data bits
            IDX_KP_MSB: prm.kp[COEFF_W-1:16] <= cfg_data[COEFF_MSB_W-1:0];
            IDX_KP_LSB: prm.kp[15:0]         <= cfg_data;
            IDX_KI_MSB: prm.ki[COEFF_W-1:16] <= cfg_data[COEFF_MSB_W-1:0];
            IDX_KI_LSB: prm.ki[15:0]         <= cfg_data;
            IDX_SETPOINT: begin
               prm.setpoint <= sample_t'(cfg_data);
            end
            IDX_LIMIT_LO: begin
               prm.limit_lo <= sample_t'(cfg_data);
            end
            IDX_LIMIT_HI: begin
               prm.limit_hi <= sample_t'(cfg_data);
            end
            IDX_DISABLED_VALUE: begin
               prm.disabled_value <= sample_t'(cfg_data);
            end
            // unknown index, write dropped
            default: begin
            end
         endcase
      end
   end

endmodule

// File: pi_param_if.sv
`timescale 1ns/1ns

interface pi_param_if import lockin_pkg::*; ();

   // gains, only picked up by the loop on their update pulse
   coeff_t  kp;
   coeff_t  ki;
   logic    kp_update;
   logic    ki_update;

   // levels, used by the loop as they are
   sample_t setpoint;
   sample_t limit_lo;
   sample_t limit_hi;
   sample_t disabled_value;

   // register bank side
   modport source (
      output kp, ki, kp_update, ki_update,
      output setpoint, limit_lo, limit_hi, disabled_value
   );

   // controller side
   modport sink (
      input kp, ki, kp_update, ki_update,
      input setpoint, limit_lo, limit_hi, disabled_value
   );

endinterface

// File: lockin_pkg.sv
package lockin_pkg;

   // datapath widths
   localparam int SAMPLE_W   = 16;
   localparam int COEFF_W    = 26;
   localparam int COEFF_FRAC = 24;

   // Q1.15 adc sample or controller value
   typedef logic signed [SAMPLE_W-1:0] sample_t;
   // Q2.24 pi coefficient, range -2 .. 1.99999
   typedef logic signed [COEFF_W-1:0]  coeff_t;
   // offset-binary dac code
   typedef logic [15:0]                dac_word_t;
   // parameter register index
   typedef logic [7:0]                 cfg_idx_t;

   // codes that mark a clipped adc channel
   localparam sample_t SAT_POS = 16'h7FFF;
   localparam sample_t SAT_NEG = 16'h8000;

   // two's complement to offset binary
   localparam dac_word_t DAC_OFFSET = 16'h8000;

   // coefficients take two writes, msb half first
   localparam cfg_idx_t IDX_KP_MSB = 8'd0;
   localparam cfg_idx_t IDX_KP_LSB = 8'd1;
   localparam cfg_idx_t IDX_KI_MSB = 8'd2;
   localparam cfg_idx_t IDX_KI_LSB = 8'd3;

   // single write registers
   localparam cfg_idx_t IDX_SETPOINT       = 8'd4;
   localparam cfg_idx_t IDX_LIMIT_LO       = 8'd5;
   localparam cfg_idx_t IDX_LIMIT_HI       = 8'd6;
   localparam cfg_idx_t IDX_DISABLED_VALUE = 8'd7;

   // bits carried by the coefficient msb write
   localparam int COEFF_MSB_W = COEFF_W - 16;

endpackage
